// ==== list.f ====
+incdir+test
hdl/gomoku_board_pkg.sv
hdl/gomoku_search_pkg.sv
hdl/board_store.sv
hdl/move_generator.sv
hdl/line_scorer.sv
hdl/minmax_search.sv
hdl/move_commit.sv
hdl/gomoku_engine.sv
test/tb_gomoku_engine.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gomoku_engine
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

SRCS := $(filter-out +%,$(shell cat list.f))
HDRS := $(wildcard test/*.svh)
BIN  := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) -Mdir $(MDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)

// ==== test/engine_model.svh ====
`ifndef ENGINE_MODEL_SVH
`define ENGINE_MODEL_SVH

// 0 empty, 1 black, 2 white, indexed [y][x]
int model_board [BOARD_N][BOARD_N];

function automatic int cell_of(int x, int y);
	if (x < 0 || y < 0 || x >= BOARD_N || y >= BOARD_N)
		return 0;	// off the board counts as empty
	return model_board[y][x];
endfunction

function automatic int stone_count();
	int n;
	n = 0;
	for (int y = 0; y < BOARD_N; y++)
		for (int x = 0; x < BOARD_N; x++)
			if (model_board[y][x] != 0)
				n++;
	return n;
endfunction

function automatic bit is_candidate(int x, int y);
	bit near;
	near = 0;
	if (cell_of(x, y) != 0)
		return 0;
	for (int dy = -1; dy <= 1; dy++)
		for (int dx = -1; dx <= 1; dx++)
			if ((dx != 0 || dy != 0) && cell_of(x + dx, y + dy) != 0)
				near = 1;
	return near;
endfunction

function automatic int line_weight(int len);
	if (len >= 5)
		return 32768;
	case (len)
		4:       return 512;
		3:       return 64;
		2:       return 8;
		default: return 1;
	endcase
endfunction

// stones of one colour touching (x, y) along one axis, plus the cell itself
function automatic int run_through(int x, int y, int dx, int dy, int colour);
	int n;
	int k;
	n = 1;
	for (k = 1; k <= 4 && cell_of(x + k * dx, y + k * dy) == colour; k++)
		n++;
	for (k = 1; k <= 4 && cell_of(x - k * dx, y - k * dy) == colour; k++)
		n++;
	return n;
endfunction

function automatic int score_cell(int x, int y, int turn);
	int own;
	int opp;
	int own_sum;
	int opp_sum;
	own = turn + 1;
	opp = 2 - turn;
	own_sum = line_weight(run_through(x, y, 1, 0, own)) + line_weight(run_through(x, y, 0, 1, own))
		+ line_weight(run_through(x, y, 1, 1, own)) + line_weight(run_through(x, y, 1, -1, own));
	opp_sum = line_weight(run_through(x, y, 1, 0, opp)) + line_weight(run_through(x, y, 0, 1, opp))
		+ line_weight(run_through(x, y, 1, 1, opp)) + line_weight(run_through(x, y, 1, -1, opp));
	return own_sum + (opp_sum >>> 1);
endfunction

// one ply, raster order, strictly greater wins, stop once bound is reached
function automatic void search_best(input int turn, input int bound, output int found,
	output int bx, output int by, output int bs);
	int  s;
	bit  stop;
	found = 0;
	bx    = 0;
	by    = 0;
	bs    = -32'sd2147483648;
	stop  = 0;
	if (stone_count() == 0) begin
		found = 1;
		bx    = 7;
		by    = 7;
		bs    = score_cell(7, 7, turn);
		return;
	end
	for (int y = 0; y < BOARD_N; y++) begin
		for (int x = 0; x < BOARD_N; x++) begin
			if (!stop && is_candidate(x, y)) begin
				s = score_cell(x, y, turn);
				if (s > bs) begin
					bs    = s;
					bx    = x;
					by    = y;
					found = 1;
				end
				if (bs >= bound)
					stop = 1;
			end
		end
	end
endfunction

`endif

// ==== test/tb_gomoku_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_gomoku_engine;
	import gomoku_board_pkg::*;
	import gomoku_search_pkg::*;

	localparam int SEARCHES        = 40;
	localparam int BOUND_MAX       = 32'h7fffffff;
	localparam int WATCHDOG_CYCLES = SEARCHES * 300 * 34 + SEARCHES * 3 * CELLS + 100;

	logic   i_clk;
	logic   i_rst_n;
	logic   i_wr_en;
	coord_t i_wr_x;
	coord_t i_wr_y;
	cell_t  i_wr_cell;
	coord_t i_rd_x;
	coord_t i_rd_y;
	cell_t  o_rd_cell;
	logic   i_start;
	logic   i_turn;
	score_t i_bound;
	logic   i_commit;
	logic   o_busy;
	logic   o_done;
	logic   o_found;
	coord_t o_move_x;
	coord_t o_move_y;
	score_t o_score;
	int     seed;
	int     t;

	`include "engine_model.svh"

	gomoku_engine dut (.*);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		$display("watchdog expired: the engine never finished a search");
		$display("Done: errors found");
		$fatal(1);
	end

	task automatic check_value(string what, int expected, int actual);
		assert (actual == expected) else begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, what, expected, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	function automatic int rand_range(int lo, int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	task automatic load_board();
		for (int y = 0; y < BOARD_N; y++) begin
			for (int x = 0; x < BOARD_N; x++) begin
				@(posedge i_clk);
				i_wr_en   <= 1'b1;
				i_wr_x    <= coord_t'(x);
				i_wr_y    <= coord_t'(y);
				i_wr_cell <= cell_t'(model_board[y][x]);
			end
		end
		@(posedge i_clk);
		i_wr_en <= 1'b0;
	endtask

	task automatic verify_board();
		for (int y = 0; y < BOARD_N; y++) begin
			for (int x = 0; x < BOARD_N; x++) begin
				@(posedge i_clk);
				i_rd_x <= coord_t'(x);
				i_rd_y <= coord_t'(y);
				@(negedge i_clk);
				check_value($sformatf("o_rd_cell(%0d,%0d)", x, y), model_board[y][x],
					int'(o_rd_cell));
			end
		end
	endtask

	task automatic make_random_board(int stones);
		int x;
		int y;
		model_board = '{default: '{default: 0}};
		for (int k = 0; k < stones; k++) begin
			x = rand_range(0, BOARD_N - 1);
			y = rand_range(0, BOARD_N - 1);
			while (model_board[y][x] != 0) begin	// retry on a taken cell
				x = rand_range(0, BOARD_N - 1);
				y = rand_range(0, BOARD_N - 1);
			end
			model_board[y][x] = rand_range(1, 2);
		end
		load_board();
		verify_board();
	endtask

	task automatic run_search(int turn, int bound, bit commit);
		int exp_found;
		int exp_x;
		int exp_y;
		int exp_score;
		search_best(turn, bound, exp_found, exp_x, exp_y, exp_score);
		@(posedge i_clk);
		i_start  <= 1'b1;
		i_turn   <= turn[0];
		i_bound  <= bound;
		i_commit <= commit;
		@(posedge i_clk);
		i_start <= 1'b0;
		@(negedge i_clk);
		check_value("o_busy", 1, int'(o_busy));
		while (!o_done)
			@(negedge i_clk);
		check_value("o_busy", 0, int'(o_busy));
		check_value("o_found", exp_found, int'(o_found));
		if (exp_found != 0) begin
			check_value("o_move_x", exp_x, int'(o_move_x));
			check_value("o_move_y", exp_y, int'(o_move_y));
			check_value("o_score", exp_score, int'(o_score));
		end
		if (commit && exp_found != 0) begin
			model_board[exp_y][exp_x] = turn + 1;
			@(posedge i_clk);
			i_rd_x <= coord_t'(exp_x);
			i_rd_y <= coord_t'(exp_y);
			@(negedge i_clk);
			check_value("o_rd_cell", turn + 1, int'(o_rd_cell));
			check_value("o_done", 0, int'(o_done));	// single cycle pulse
		end
	endtask

	initial begin
		seed      = 1178;
		i_rst_n   = 1'b0;
		i_wr_en   = 1'b0;
		i_wr_x    = '0;
		i_wr_y    = '0;
		i_wr_cell = CELL_EMPTY;
		i_rd_x    = '0;
		i_rd_y    = '0;
		i_start   = 1'b0;
		i_turn    = 1'b0;
		i_bound   = '0;
		i_commit  = 1'b0;
		model_board = '{default: '{default: 0}};
		repeat (8) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(negedge i_clk);
		check_value("o_busy", 0, int'(o_busy));
		check_value("o_done", 0, int'(o_done));
		check_value("o_found", 0, int'(o_found));
		verify_board();

		run_search(0, BOUND_MAX, 1'b0);	// opening move

		for (int b = 0; b < 12; b++) begin
			make_random_board(rand_range(5, 40));
			run_search(rand_range(0, 1), BOUND_MAX, 1'b0);
		end

		// bounds around and below typical scores
		for (int b = 0; b < 12; b++) begin
			make_random_board(rand_range(5, 40));
			run_search(rand_range(0, 1), rand_range(-5, 600), 1'b0);
		end

		for (int b = 0; b < 6; b++) begin
			make_random_board(rand_range(5, 40));
			t = rand_range(0, 1);
			run_search(t, BOUND_MAX, 1'b1);
			run_search(1 - t, BOUND_MAX, 1'b1);	// sees the committed stone
		end

		// every cell taken, nothing to play
		for (int y = 0; y < BOARD_N; y++)
			for (int x = 0; x < BOARD_N; x++)
				model_board[y][x] = rand_range(1, 2);
		load_board();
		run_search(0, BOUND_MAX, 1'b1);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/gomoku_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module gomoku_engine (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_wr_en,
	input  gomoku_board_pkg::coord_t  i_wr_x,
	input  gomoku_board_pkg::coord_t  i_wr_y,
	input  gomoku_board_pkg::cell_t   i_wr_cell,
	input  gomoku_board_pkg::coord_t  i_rd_x,
	input  gomoku_board_pkg::coord_t  i_rd_y,
	output gomoku_board_pkg::cell_t   o_rd_cell,
	input  logic                      i_start,
	input  logic                      i_turn,
	input  gomoku_search_pkg::score_t i_bound,
	input  logic                      i_commit,
	output logic                      o_busy,
	output logic                      o_done,
	output logic                      o_found,
	output gomoku_board_pkg::coord_t  o_move_x,
	output gomoku_board_pkg::coord_t  o_move_y,
	output gomoku_search_pkg::score_t o_score
);
	import gomoku_board_pkg::*;

	board_t                    board;
	logic                      gen_start;
	logic                      gen_next;
	logic                      gen_valid;
	logic                      gen_end;
	coord_t                    gen_x;
	coord_t                    gen_y;
	logic                      sc_start;
	coord_t                    sc_x;
	coord_t                    sc_y;
	logic                      sc_turn;	// latched mover, also colours the commit
	logic                      sc_done;
	gomoku_search_pkg::score_t sc_score;
	logic                      res_valid;
	logic                      res_found;
	coord_t                    res_x;
	coord_t                    res_y;
	gomoku_search_pkg::score_t res_score;
	logic                      res_commit;
	logic                      c_wr_en;
	coord_t                    c_wr_x;
	coord_t                    c_wr_y;
	cell_t                     c_wr_cell;

	board_store u_board (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_wr_en(i_wr_en), .i_wr_x(i_wr_x), .i_wr_y(i_wr_y), .i_wr_cell(i_wr_cell),
		.i_cwr_en(c_wr_en), .i_cwr_x(c_wr_x), .i_cwr_y(c_wr_y), .i_cwr_cell(c_wr_cell),
		.i_rd_x(i_rd_x), .i_rd_y(i_rd_y), .o_rd_cell(o_rd_cell), .o_board(board)
	);

	move_generator u_gen (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_board(board),
		.i_start(gen_start), .i_next(gen_next),
		.o_valid(gen_valid), .o_end(gen_end), .o_x(gen_x), .o_y(gen_y)
	);

	line_scorer u_scorer (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_board(board),
		.i_start(sc_start), .i_x(sc_x), .i_y(sc_y), .i_turn(sc_turn),
		.o_done(sc_done), .o_score(sc_score)
	);

	minmax_search u_search (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_start(i_start), .i_turn(i_turn), .i_bound(i_bound), .i_commit(i_commit),
		.o_busy(o_busy),
		.o_gen_start(gen_start), .o_gen_next(gen_next), .i_gen_valid(gen_valid),
		.i_gen_end(gen_end), .i_gen_x(gen_x), .i_gen_y(gen_y),
		.o_sc_start(sc_start), .o_sc_x(sc_x), .o_sc_y(sc_y), .o_sc_turn(sc_turn),
		.i_sc_done(sc_done), .i_sc_score(sc_score),
		.o_res_valid(res_valid), .o_res_found(res_found), .o_res_x(res_x),
		.o_res_y(res_y), .o_res_score(res_score), .o_res_commit(res_commit)
	);

	move_commit u_commit (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_res_valid(res_valid), .i_res_found(res_found), .i_res_x(res_x),
		.i_res_y(res_y), .i_res_score(res_score), .i_res_commit(res_commit),
		.i_turn(sc_turn),
		.o_cwr_en(c_wr_en), .o_cwr_x(c_wr_x), .o_cwr_y(c_wr_y), .o_cwr_cell(c_wr_cell),
		.o_done(o_done), .o_found(o_found), .o_move_x(o_move_x), .o_move_y(o_move_y),
		.o_score(o_score)
	);

endmodule

`default_nettype wire

// ==== hdl/move_commit.sv ====
`timescale 1ns/1ns
`default_nettype none

module move_commit (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_res_valid,
	input  logic                      i_res_found,
	input  gomoku_board_pkg::coord_t  i_res_x,
	input  gomoku_board_pkg::coord_t  i_res_y,
	input  gomoku_search_pkg::score_t i_res_score,
	input  logic                      i_res_commit,
	input  logic                      i_turn,
	output logic                      o_cwr_en,
	output gomoku_board_pkg::coord_t  o_cwr_x,
	output gomoku_board_pkg::coord_t  o_cwr_y,
	output gomoku_board_pkg::cell_t   o_cwr_cell,
	output logic                      o_done,
	output logic                      o_found,
	output gomoku_board_pkg::coord_t  o_move_x,
	output gomoku_board_pkg::coord_t  o_move_y,
	output gomoku_search_pkg::score_t o_score
);
	import gomoku_board_pkg::*;
	import gomoku_search_pkg::*;

	coord_t x_q;
	coord_t y_q;
	score_t score_q;

	assign o_move_x   = x_q;
	assign o_move_y   = y_q;
	assign o_score    = score_q;
	assign o_cwr_x    = x_q;
	assign o_cwr_y    = y_q;
	assign o_cwr_cell = i_turn ? CELL_WHITE : CELL_BLACK;	// mover's stone

	always_ff @(posedge i_clk, negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cwr_en <= 1'b0;
			o_done   <= 1'b0;
			o_found  <= 1'b0;
		end
		else begin
			o_cwr_en <= i_res_valid && i_res_found && i_res_commit;
			// done waits one cycle behind the write
			o_done <= o_cwr_en || (i_res_valid && !(i_res_found && i_res_commit));
			if (i_res_valid)
				o_found <= i_res_found;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_res_valid) begin
			x_q     <= i_res_x;
			y_q     <= i_res_y;
			score_q <= i_res_score;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/minmax_search.sv ====
`timescale 1ns/1ns
`default_nettype none

module minmax_search (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_start,
	input  logic                      i_turn,
	input  gomoku_search_pkg::score_t i_bound,
	input  logic                      i_commit,
	output logic                      o_busy,
	output logic                      o_gen_start,
	output logic                      o_gen_next,
	input  logic                      i_gen_valid,
	input  logic                      i_gen_end,
	input  gomoku_board_pkg::coord_t  i_gen_x,
	input  gomoku_board_pkg::coord_t  i_gen_y,
	output logic                      o_sc_start,
	output gomoku_board_pkg::coord_t  o_sc_x,
	output gomoku_board_pkg::coord_t  o_sc_y,
	output logic                      o_sc_turn,
	input  logic                      i_sc_done,
	input  gomoku_search_pkg::score_t i_sc_score,
	output logic                      o_res_valid,
	output logic                      o_res_found,
	output gomoku_board_pkg::coord_t  o_res_x,
	output gomoku_board_pkg::coord_t  o_res_y,
	output gomoku_search_pkg::score_t o_res_score,
	output logic                      o_res_commit
);
	import gomoku_board_pkg::*;
	import gomoku_search_pkg::*;

	srch_state_t state_r, state_w;
	logic        found_r, found_w;
	score_t      best_r, best_w;
	coord_t      best_x_r, best_x_w;
	coord_t      best_y_r, best_y_w;
	logic        gen_start_w;
	logic        gen_next_w;
	logic        sc_start_w;
	logic        res_valid_w;
	logic        turn_q;
	logic        commit_q;
	score_t      bound_q;
	coord_t      cand_x;
	coord_t      cand_y;

	assign o_busy       = (state_r != S_IDLE);
	assign o_sc_x       = cand_x;
	assign o_sc_y       = cand_y;
	assign o_sc_turn    = turn_q;
	assign o_res_found  = found_r;
	assign o_res_x      = best_x_r;
	assign o_res_y      = best_y_r;
	assign o_res_score  = best_r;
	assign o_res_commit = commit_q;

	always_comb begin
		state_w     = state_r;
		found_w     = found_r;
		best_w      = best_r;
		best_x_w    = best_x_r;
		best_y_w    = best_y_r;
		gen_start_w = 1'b0;
		gen_next_w  = 1'b0;
		sc_start_w  = 1'b0;
		res_valid_w = 1'b0;
		case (state_r)
			S_IDLE: if (i_start) begin
				found_w     = 1'b0;
				best_w      = SCORE_MIN;
				gen_start_w = 1'b1;
				state_w     = S_GEN;
			end
			S_GEN: if (i_gen_valid) begin
				sc_start_w = 1'b1;
				state_w    = S_SCORE;
			end
			else if (i_gen_end) begin
				res_valid_w = 1'b1;
				state_w     = S_DONE;
			end
			S_SCORE: if (i_sc_done) begin
				if (i_sc_score > best_r) begin	// ties keep the earlier cell
					best_w   = i_sc_score;
					best_x_w = cand_x;
					best_y_w = cand_y;
					found_w  = 1'b1;
				end
				if (best_w >= bound_q) begin	// good enough, cut off
					res_valid_w = 1'b1;
					state_w     = S_DONE;
				end
				else begin
					gen_next_w = 1'b1;
					state_w    = S_GEN;
				end
			end
			// one extra cycle while the stone is written back
			S_DONE: if (!(o_res_valid && commit_q && found_r))
				state_w = S_IDLE;
			default: state_w = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk, negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r     <= S_IDLE;
			found_r     <= 1'b0;
			o_gen_start <= 1'b0;
			o_gen_next  <= 1'b0;
			o_sc_start  <= 1'b0;
			o_res_valid <= 1'b0;
		end
		else begin
			state_r     <= state_w;
			found_r     <= found_w;
			o_gen_start <= gen_start_w;
			o_gen_next  <= gen_next_w;
			o_sc_start  <= sc_start_w;
			o_res_valid <= res_valid_w;
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_r == S_IDLE && i_start) begin
			turn_q   <= i_turn;
			bound_q  <= i_bound;
			commit_q <= i_commit;
		end
		if (state_r == S_GEN && i_gen_valid) begin
			cand_x <= i_gen_x;
			cand_y <= i_gen_y;
		end
		best_r   <= best_w;
		best_x_r <= best_x_w;
		best_y_r <= best_y_w;
	end

	a_sc_in_score: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_sc_done |-> state_r == S_SCORE);

endmodule

`default_nettype wire

// ==== hdl/line_scorer.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_scorer (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  gomoku_board_pkg::board_t  i_board,
	input  logic                      i_start,
	input  gomoku_board_pkg::coord_t  i_x,
	input  gomoku_board_pkg::coord_t  i_y,
	input  logic                      i_turn,
	output logic                      o_done,
	output gomoku_search_pkg::score_t o_score
);
	import gomoku_board_pkg::*;
	import gomoku_search_pkg::*;

	logic       busy;
	logic [2:0] ray;	// axis in [2:1], direction in [0]
	logic [1:0] step;
	coord_t     x_q;
	coord_t     y_q;
	cell_t      own_c;
	cell_t      opp_c;
	logic       own_go;
	logic       opp_go;
	logic [3:0] own_run;	// both rays of the axis
	logic [3:0] opp_run;
	score_t     own_acc;
	score_t     opp_acc;
	int         dx;
	int         dy;
	int         px;
	int         py;
	logic       inb;
	cell_t      cur;
	logic       own_hit;
	logic       opp_hit;
	logic [3:0] own_nx;
	logic [3:0] opp_nx;
	logic       last_step;
	logic       axis_end;

	always_comb begin
		dx = (ray[2:1] == 2'd1) ? 0 : 1;
		dy = (ray[2:1] == 2'd0) ? 0 : ((ray[2:1] == 2'd3) ? -1 : 1);
		if (ray[0]) begin
			dx = -dx;
			dy = -dy;
		end
		px  = int'(x_q) + dx * (int'(step) + 1);
		py  = int'(y_q) + dy * (int'(step) + 1);
		inb = px >= 0 && py >= 0 && px < BOARD_N && py < BOARD_N;
		cur = inb ? cell_at(i_board, py * BOARD_N + px) : CELL_EMPTY;
	end

	assign own_hit   = own_go && cur == own_c;
	assign opp_hit   = opp_go && cur == opp_c;
	assign own_nx    = own_run + {3'd0, own_hit};
	assign opp_nx    = opp_run + {3'd0, opp_hit};
	assign last_step = (step == 2'd3);
	assign axis_end  = last_step && ray[0];
	assign o_score   = own_acc + (opp_acc >>> 1);	// defence counts half

	always_ff @(posedge i_clk, negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy   <= 1'b0;
			ray    <= '0;
			step   <= '0;
			o_done <= 1'b0;
		end
		else begin
			o_done <= busy && last_step && ray == 3'd7;
			if (i_start) begin
				busy <= 1'b1;
				ray  <= '0;
				step <= '0;
			end
			else if (busy) begin
				step <= step + 2'd1;
				if (last_step) begin
					ray <= ray + 3'd1;
					if (ray == 3'd7)
						busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			x_q     <= i_x;
			y_q     <= i_y;
			own_c   <= i_turn ? CELL_WHITE : CELL_BLACK;
			opp_c   <= i_turn ? CELL_BLACK : CELL_WHITE;
			own_go  <= 1'b1;
			opp_go  <= 1'b1;
			own_run <= '0;
			opp_run <= '0;
			own_acc <= '0;
			opp_acc <= '0;
		end
		else if (busy) begin
			own_go  <= own_hit || last_step;	// a gap ends the run
			opp_go  <= opp_hit || last_step;
			own_run <= axis_end ? 4'd0 : own_nx;
			opp_run <= axis_end ? 4'd0 : opp_nx;
			if (axis_end) begin
				own_acc <= own_acc + run_weight(int'(own_nx) + 1);
				opp_acc <= opp_acc + run_weight(int'(opp_nx) + 1);
			end
		end
	end

	a_no_restart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_start |-> !busy);

endmodule

`default_nettype wire

// ==== hdl/move_generator.sv ====
`timescale 1ns/1ns
`default_nettype none

module move_generator (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  gomoku_board_pkg::board_t i_board,
	input  logic                     i_start,
	input  logic                     i_next,
	output logic                     o_valid,
	output logic                     o_end,
	output gomoku_board_pkg::coord_t o_x,
	output gomoku_board_pkg::coord_t o_y
);
	import gomoku_board_pkg::*;
	import gomoku_search_pkg::*;

	logic   scan;
	logic   empty_q;	// nothing seen on the board so far
	coord_t cx;
	coord_t cy;
	coord_t nx_x;
	coord_t nx_y;
	logic   at_end;
	cell_t  cur;
	logic   cand;
	logic   fallback;

	assign at_end   = (cy == coord_t'(BOARD_N));
	assign cur      = cell_at(i_board, at_end ? 0 : int'(cy) * BOARD_N + int'(cx));
	assign cand     = !at_end && cur == CELL_EMPTY && has_neighbour(i_board, cx, cy);
	assign fallback = at_end && empty_q &&
		cell_at(i_board, int'(CENTER) * BOARD_N + int'(CENTER)) == CELL_EMPTY;

	assign o_valid = scan && (cand || fallback);
	assign o_end   = scan && at_end && !fallback;
	assign o_x     = at_end ? CENTER : cx;
	assign o_y     = at_end ? CENTER : cy;

	// raster step with x inner
	always_comb begin
		nx_x = cx + 4'd1;
		nx_y = cy;
		if (cx == coord_t'(BOARD_N - 1)) begin
			nx_x = '0;
			nx_y = cy + 4'd1;
		end
	end

	always_ff @(posedge i_clk, negedge i_rst_n) begin
		if (!i_rst_n) begin
			scan    <= 1'b0;
			empty_q <= 1'b0;
			cx      <= '0;
			cy      <= '0;
		end
		else if (i_start) begin
			scan    <= 1'b1;
			empty_q <= 1'b1;
			cx      <= '0;
			cy      <= '0;
		end
		else if (i_next) begin
			scan <= 1'b1;
			if (!at_end) begin	// step past the cell just reported
				cx <= nx_x;
				cy <= nx_y;
			end
		end
		else if (scan) begin
			if (o_valid || o_end)
				scan <= 1'b0;
			else begin
				cx <= nx_x;
				cy <= nx_y;
			end
			if (at_end)
				empty_q <= 1'b0;	// centre handed out once only
			else
				empty_q <= empty_q && cur == CELL_EMPTY;
		end
	end

	a_req_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_start || i_next) |-> !scan);

endmodule

`default_nettype wire

// ==== hdl/board_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module board_store (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_wr_en,
	input  gomoku_board_pkg::coord_t i_wr_x,
	input  gomoku_board_pkg::coord_t i_wr_y,
	input  gomoku_board_pkg::cell_t  i_wr_cell,
	input  logic                     i_cwr_en,
	input  gomoku_board_pkg::coord_t i_cwr_x,
	input  gomoku_board_pkg::coord_t i_cwr_y,
	input  gomoku_board_pkg::cell_t  i_cwr_cell,
	input  gomoku_board_pkg::coord_t i_rd_x,
	input  gomoku_board_pkg::coord_t i_rd_y,
	output gomoku_board_pkg::cell_t  o_rd_cell,
	output gomoku_board_pkg::board_t o_board
);
	import gomoku_board_pkg::*;

	board_t board_q;
	int     wr_idx;
	int     cwr_idx;
	int     rd_idx;

	always_comb begin
		wr_idx  = int'(i_wr_y) * BOARD_N + int'(i_wr_x);
		cwr_idx = int'(i_cwr_y) * BOARD_N + int'(i_cwr_x);
		rd_idx  = int'(i_rd_y) * BOARD_N + int'(i_rd_x);
	end

	assign o_board   = board_q;
	assign o_rd_cell = cell_at(board_q, rd_idx);	// async read

	always_ff @(posedge i_clk, negedge i_rst_n) begin
		if (!i_rst_n) begin
			board_q <= '0;
		end
		else if (i_cwr_en) begin	// commit port wins
			board_q[2*cwr_idx +: 2] <= i_cwr_cell;
		end
		else if (i_wr_en) begin
			board_q[2*wr_idx +: 2] <= i_wr_cell;
		end
	end

	a_wr_coord: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_wr_en |-> (i_wr_x < BOARD_N && i_wr_y < BOARD_N));
	a_cwr_coord: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_cwr_en |-> (i_cwr_x < BOARD_N && i_cwr_y < BOARD_N));

endmodule

`default_nettype wire

// ==== hdl/gomoku_search_pkg.sv ====
`default_nettype none

package gomoku_search_pkg;

	typedef logic signed [31:0] score_t;

	localparam int     RUN_MAX   = 5;
	localparam score_t W_LEN1    = 32'sd1;
	localparam score_t W_LEN2    = 32'sd8;
	localparam score_t W_LEN3    = 32'sd64;
	localparam score_t W_LEN4    = 32'sd512;
	localparam score_t W_WIN     = 32'sd32768;
	localparam score_t SCORE_MIN = {1'b1, {31{1'b0}}};

	typedef enum logic [1:0] {
		S_IDLE,
		S_GEN,
		S_SCORE,
		S_DONE
	} srch_state_t;

	// weight of a run of len stones through the cell
	function automatic score_t run_weight(int len);
		if (len >= RUN_MAX)
			return W_WIN;
		case (len)
			4:       return W_LEN4;
			3:       return W_LEN3;
			2:       return W_LEN2;
			default: return W_LEN1;
		endcase
	endfunction

	// any stone among the up to eight cells around (x, y)
	function automatic logic has_neighbour(
		gomoku_board_pkg::board_t b,
		gomoku_board_pkg::coord_t x,
		gomoku_board_pkg::coord_t y
	);
		int   nx;
		int   ny;
		logic hit;
		hit = 1'b0;
		for (int dy = -1; dy <= 1; dy++) begin
			for (int dx = -1; dx <= 1; dx++) begin
				nx = int'(x) + dx;
				ny = int'(y) + dy;
				if ((dx != 0 || dy != 0) && nx >= 0 && ny >= 0 &&
					nx < gomoku_board_pkg::BOARD_N && ny < gomoku_board_pkg::BOARD_N)
					hit = hit | (gomoku_board_pkg::cell_at(b, ny * gomoku_board_pkg::BOARD_N + nx)
						!= gomoku_board_pkg::CELL_EMPTY);
			end
		end
		return hit;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/gomoku_board_pkg.sv ====
`default_nettype none

package gomoku_board_pkg;

	localparam int BOARD_N = 15;
	localparam int CELLS   = BOARD_N * BOARD_N;

	typedef logic [3:0] coord_t;

	typedef enum logic [1:0] {
		CELL_EMPTY = 2'd0,
		CELL_BLACK = 2'd1,
		CELL_WHITE = 2'd2
	} cell_t;

	// cell i sits at bits [2i+1:2i], i = y*15 + x
	typedef logic [2*CELLS-1:0] board_t;

	localparam coord_t CENTER = 4'd7;	// opening move on an empty board

	function automatic cell_t cell_at(board_t b, int idx);
		return cell_t'(b[2*idx +: 2]);
	endfunction

endpackage

`default_nettype wire
